// ==== flist.f ====
common/resp_bank_pkg.sv
rtl/slot_allocator.sv
rtl/id_queue/id_queue.sv
rtl/bank_storage.sv
rtl/release_arbiter.sv
rtl/resp_bank_top.sv
dv/tb_clk_gen.sv
dv/resp_bank_asserts.sv
dv/tb_resp_bank.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_resp_bank
FLIST     := flist.f
VFLAGS    := --binary --timing --assert --top-module $(TOP)

SIM_BIN   := obj_dir/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== dv/tb_resp_bank.sv ====
/*
 * Testbench of the response bank
 * Random stimulus, reference model per identifier, compare process
 */

`default_nettype none

module tb_resp_bank;

  import resp_bank_pkg::*;

  localparam int NumIds       = NUM_IDS;
  localparam int NumCells     = NUM_CELLS;
  localparam int DrainTimeout = 4000;

  logic                clk;
  logic                rst_n;
  logic                rsv_valid;
  logic [NumIds-1:0]   rsv_id_onehot;
  logic                rsv_ready;
  cell_t               rsv_addr;
  logic                in_valid;
  msg_word_u           in_data;
  logic                in_ready;
  logic                out_ready;
  logic [NumCells-1:0] release_en;
  logic                out_valid;
  msg_word_u           out_data;
  logic [NumCells-1:0] released_onehot;

  // Reference model
  logic [NumCells-1:0]  model_occ;
  cell_t                q_cell [NumIds][$];
  logic [PAYLOAD_W-1:0] q_pay [NumIds][$];
  logic                 prev_valid;
  logic                 prev_ready;
  msg_word_u            prev_data;
  logic [NumCells-1:0]  prev_rel_en;
  logic [NumCells-1:0]  sel_rel_en;

  tb_clk_gen #(
    .HalfPeriod  (2),
    .ResetCycles (16)
  ) tb_clk_gen_i (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  resp_bank_top #(
    .NumIds   (NumIds),
    .NumCells (NumCells)
  ) resp_bank_top_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .i_rsv_valid       (rsv_valid),
    .i_rsv_id_onehot   (rsv_id_onehot),
    .o_rsv_ready       (rsv_ready),
    .o_rsv_addr        (rsv_addr),
    .i_in_valid        (in_valid),
    .i_in_data         (in_data),
    .o_in_ready        (in_ready),
    .i_out_ready       (out_ready),
    .i_release_en      (release_en),
    .o_out_valid       (out_valid),
    .o_out_data        (out_data),
    .o_released_onehot (released_onehot)
  );

  ////////////////////////////////////////
  // Reporting and reference functions
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    end
  endtask

  function automatic int lowest_free(input logic [NumCells-1:0] occ);
    int found;
    found = -1;
    for (int c = 0; c < NumCells; c++) begin
      if (found < 0 && !occ[c]) begin
        found = c;
      end
    end
    return found;
  endfunction

  function automatic int onehot_to_id(input logic [NumIds-1:0] oh);
    int id;
    id = 0;
    for (int k = 0; k < NumIds; k++) begin
      if (oh[k]) begin
        id = k;
      end
    end
    return id;
  endfunction

  function automatic bit has_unfilled(input int id);
    if (id >= NumIds) begin
      return 1'b0;
    end
    return q_cell[id].size() > q_pay[id].size();
  endfunction

  function automatic bit model_empty();
    for (int k = 0; k < NumIds; k++) begin
      if (q_cell[k].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Mostly an identifier that still waits for data
  function automatic int pick_fill_id();
    int start;
    int id;
    start = int'($urandom % NumIds);
    if ($urandom % 4 == 0) begin
      return start;
    end
    for (int k = 0; k < NumIds; k++) begin
      id = (start + k) % NumIds;
      if (has_unfilled(id)) begin
        return id;
      end
    end
    return start;
  endfunction

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(negedge clk) begin : compare
    int    id;
    cell_t front;
    if (!rst_n) begin
      model_occ   = '0;
      prev_valid  = 1'b0;
      prev_ready  = 1'b0;
      prev_data   = '0;
      prev_rel_en = '0;
      sel_rel_en  = '0;
    end else begin
      check_val("o_rsv_ready", 32'(rsv_ready), 32'(~&model_occ));
      check_val("o_in_ready", 32'(in_ready),
                32'(in_valid && has_unfilled(int'(in_data.fields.id))));
      // Offered cell is the lowest free one whenever any cell is free
      if (rsv_ready) begin
        check_val("o_rsv_addr", 32'(rsv_addr), 32'(lowest_free(model_occ)));
      end
      if (prev_valid && !prev_ready) begin
        check_val("o_out_valid", 32'(out_valid), 32'd1);
        check_val("o_out_data", 32'(out_data.raw), 32'(prev_data.raw));
      end
      // A new item was selected at the last edge
      if (out_valid && (!prev_valid || prev_ready)) begin
        sel_rel_en = prev_rel_en;
        if (prev_rel_en == '0) begin
          abort_run("o_out_valid rose while every release bit was low");
        end
      end
      if (out_valid && out_ready) begin
        id = int'(out_data.fields.id);
        if (id >= NumIds || q_pay[id].size() == 0) begin
          abort_run("An item completed that the model holds no filled entry for");
        end
        front = q_cell[id][0];
        check_val("o_out_data.payload", 32'(out_data.fields.payload), 32'(q_pay[id][0]));
        check_val("o_released_onehot", 32'(released_onehot), 32'(1) << front);
        check_val("release bit at selection", 32'(sel_rel_en[front]), 32'd1);
        model_occ[front] = 1'b0;
        void'(q_cell[id].pop_front());
        void'(q_pay[id].pop_front());
      end else begin
        check_val("o_released_onehot", 32'(released_onehot), 32'd0);
      end
      if (in_valid && in_ready) begin
        q_pay[int'(in_data.fields.id)].push_back(in_data.fields.payload);
      end
      if (rsv_valid && rsv_ready) begin
        id = onehot_to_id(rsv_id_onehot);
        q_cell[id].push_back(rsv_addr);
        model_occ[rsv_addr] = 1'b1;
      end
      prev_valid  = out_valid;
      prev_ready  = out_ready;
      prev_data   = out_data;
      prev_rel_en = release_en;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_cycle(input bit rsv_on, input bit zero_rel, input bit hold_out);
    int unsigned rid;
    int          fid;
    @(posedge clk);
    rid = $urandom % NumIds;
    fid = pick_fill_id();
    rsv_valid              <= rsv_on && ($urandom % 2 == 0);
    rsv_id_onehot          <= NumIds'(1) << rid;
    in_valid               <= ($urandom % 4) != 0;
    in_data.fields.id      <= ID_W'(fid);
    in_data.fields.payload <= PAYLOAD_W'($urandom);
    release_en             <= zero_rel ? '0 : NumCells'($urandom);
    out_ready              <= hold_out ? 1'b0 : (($urandom % 4) != 0);
  endtask

  initial begin : stimulus
    int wait_cnt;
    void'($urandom(72662));
    rsv_valid     <= 1'b0;
    rsv_id_onehot <= '0;
    in_valid      <= 1'b0;
    in_data       <= '0;
    out_ready     <= 1'b0;
    release_en    <= '0;

    wait_cnt = 0;
    while (!rst_n) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > 100) begin
        abort_run("Timeout: reset was never released");
      end
    end
    @(negedge clk);
    check_val("o_out_valid", 32'(out_valid), 32'd0);
    check_val("o_in_ready", 32'(in_ready), 32'd0);
    check_val("o_rsv_ready", 32'(rsv_ready), 32'd1);
    check_val("o_rsv_addr", 32'(rsv_addr), 32'd0);

    repeat (400) drive_cycle(1'b1, 1'b0, 1'b0);
    // Nothing may leave, cells fill up
    repeat (40) drive_cycle(1'b1, 1'b1, 1'b0);
    repeat (30) drive_cycle(1'b1, 1'b0, 1'b1);
    repeat (300) drive_cycle(1'b1, 1'b0, 1'b0);

    wait_cnt = 0;
    while (!model_empty()) begin
      drive_cycle(1'b0, 1'b0, 1'b0);
      wait_cnt++;
      if (wait_cnt > DrainTimeout) begin
        abort_run("Timeout: the bank did not drain");
      end
    end
    repeat (4) drive_cycle(1'b0, 1'b0, 1'b0);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/resp_bank_asserts.sv ====
/*
 * Output protocol assertions of the response bank
 * Bound to the top level
 */

`default_nettype none

module resp_bank_asserts #(
  parameter int NumCells = resp_bank_pkg::NUM_CELLS
) (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     o_out_valid,
  input logic                     i_out_ready,
  input resp_bank_pkg::msg_word_u o_out_data,
  input logic [NumCells-1:0]      i_release_en,
  input logic                     o_rsv_ready,
  input resp_bank_pkg::cell_t     o_rsv_addr,
  input logic [NumCells-1:0]      o_released_onehot
);

  // Held item stays put until it is taken
  out_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data.raw)))
    else $error("output changed while back-pressured");

  // A released cell is still occupied, so the allocator cannot offer it
  released_cell_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(o_released_onehot) && !(o_rsv_ready && o_released_onehot[o_rsv_addr]))
    else $error("released cell is not a single occupied cell");

  // Nothing is selected while every release bit is low
  release_gate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((!o_out_valid || i_out_ready) && (i_release_en == '0)) |=> !o_out_valid)
    else $error("item selected with no release bit set");

endmodule

bind resp_bank_top resp_bank_asserts #(
  .NumCells (NumCells)
) resp_bank_asserts_i (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .o_out_valid       (o_out_valid),
  .i_out_ready       (i_out_ready),
  .o_out_data        (o_out_data),
  .i_release_en      (i_release_en),
  .o_rsv_ready       (o_rsv_ready),
  .o_rsv_addr        (o_rsv_addr),
  .o_released_onehot (o_released_onehot)
);

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
/*
 * Testbench clock and reset generator
 */

`default_nettype none

module tb_clk_gen #(
  parameter int HalfPeriod  = 2,
  parameter int ResetCycles = 16
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(HalfPeriod) o_clk = ~o_clk;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    o_rst_n <= 1'b0;
    repeat (ResetCycles) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== rtl/resp_bank_top.sv ====
/*
 * Response bank top level
 * Slot allocator, one linked-list queue per identifier, cell storage and release arbiter
 */

`default_nettype none

module resp_bank_top #(
  parameter int NumIds   = resp_bank_pkg::NUM_IDS,
  parameter int NumCells = resp_bank_pkg::NUM_CELLS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_valid,
  input  logic [NumIds-1:0]        i_rsv_id_onehot,
  output logic                     o_rsv_ready,
  output resp_bank_pkg::cell_t     o_rsv_addr,
  input  logic                     i_in_valid,
  input  resp_bank_pkg::msg_word_u i_in_data,
  output logic                     o_in_ready,
  input  logic                     i_out_ready,
  input  logic [NumCells-1:0]      i_release_en,
  output logic                     o_out_valid,
  output resp_bank_pkg::msg_word_u o_out_data,
  output logic [NumCells-1:0]      o_released_onehot
);

  import resp_bank_pkg::*;

  logic              rsv_fire;
  logic              in_fire;
  logic [NumIds-1:0] accepts;
  logic [NumIds-1:0] has_filled;
  logic [NumIds-1:0] link_we;
  logic [NumIds-1:0] pop;
  cell_t             link_addr [NumIds];
  cell_t             fill_addr [NumIds];
  cell_t             head [NumIds];
  cell_t             mid_next [NumIds];
  cell_t             head_next [NumIds];
  cell_t             rd_cell;
  msg_word_u         rd_data;

  // Input side handshake, ready follows valid
  assign o_in_ready = i_in_valid & (|accepts);
  assign in_fire    = i_in_valid & o_in_ready;

  slot_allocator #(
    .NumCells (NumCells)
  ) slot_allocator_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_rsv_valid       (i_rsv_valid),
    .i_released_onehot (o_released_onehot),
    .o_rsv_ready       (o_rsv_ready),
    .o_free_cell       (o_rsv_addr),
    .o_rsv_fire        (rsv_fire)
  );

  for (genvar g = 0; g < NumIds; g++) begin : g_queue
    id_queue #(
      .NumCells (NumCells),
      .QueueId  (g)
    ) id_queue_i (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .i_rsv_fire   (rsv_fire),
      .i_rsv_sel    (i_rsv_id_onehot[g]),
      .i_free_cell  (o_rsv_addr),
      .i_in_fire    (in_fire),
      .i_in_data    (i_in_data),
      .i_pop        (pop[g]),
      .i_mid_next   (mid_next[g]),
      .i_head_next  (head_next[g]),
      .o_link_we    (link_we[g]),
      .o_link_addr  (link_addr[g]),
      .o_fill_addr  (fill_addr[g]),
      .o_head       (head[g]),
      .o_accepts    (accepts[g]),
      .o_has_filled (has_filled[g])
    );
  end

  bank_storage #(
    .NumIds   (NumIds),
    .NumCells (NumCells)
  ) bank_storage_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_in_fire   (in_fire),
    .i_in_data   (i_in_data),
    .i_fill_addr (fill_addr),
    .i_in_sel    (accepts),
    .i_link_we   (link_we),
    .i_link_addr (link_addr),
    .i_free_cell (o_rsv_addr),
    .i_rd_cell   (rd_cell),
    .i_mid_cell  (fill_addr),
    .i_head_cell (head),
    .o_rd_data   (rd_data),
    .o_mid_next  (mid_next),
    .o_head_next (head_next)
  );

  release_arbiter #(
    .NumIds   (NumIds),
    .NumCells (NumCells)
  ) release_arbiter_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_has_filled      (has_filled),
    .i_head            (head),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .i_rd_data         (rd_data),
    .o_pop             (pop),
    .o_rd_cell         (rd_cell),
    .o_out_valid       (o_out_valid),
    .o_out_data        (o_out_data),
    .o_released_onehot (o_released_onehot)
  );

endmodule

`default_nettype wire

// ==== rtl/release_arbiter.sv ====
/*
 * Release arbitration and output register
 * Lowest eligible identifier wins, released cell reported on handshake
 */

`default_nettype none

module release_arbiter #(
  parameter int NumIds   = resp_bank_pkg::NUM_IDS,
  parameter int NumCells = resp_bank_pkg::NUM_CELLS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [NumIds-1:0]        i_has_filled,
  input  resp_bank_pkg::cell_t     i_head [NumIds],
  input  logic [NumCells-1:0]      i_release_en,
  input  logic                     i_out_ready,
  input  resp_bank_pkg::msg_word_u i_rd_data,
  output logic [NumIds-1:0]        o_pop,
  output resp_bank_pkg::cell_t     o_rd_cell,
  output logic                     o_out_valid,
  output resp_bank_pkg::msg_word_u o_out_data,
  output logic [NumCells-1:0]      o_released_onehot
);

  import resp_bank_pkg::*;

  logic [NumIds-1:0] eligible;
  logic [ID_W-1:0]   win_id;
  logic              reg_free;
  logic              load;
  logic              valid_q;
  msg_word_u         data_q;
  cell_t             cell_q;

  // Filled head whose release bit is set
  for (genvar g = 0; g < NumIds; g++) begin : g_elig
    assign eligible[g] = i_has_filled[g] & i_release_en[i_head[g]];
    assign o_pop[g]    = load && (win_id == ID_W'(g));
  end

  always_comb begin
    win_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        win_id = ID_W'(i);
      end
    end
  end

  // Register is empty or its item completes this cycle
  assign reg_free  = ~valid_q | i_out_ready;
  assign load      = reg_free & (|eligible);
  assign o_rd_cell = i_head[win_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (reg_free) begin
      valid_q <= |eligible;
    end
  end

  // Identifier comes from the winner, payload from the cell
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q.fields.id      <= win_id;
      data_q.fields.payload <= i_rd_data.fields.payload;
      cell_q                <= o_rd_cell;
    end
  end

  assign o_out_valid = valid_q;
  assign o_out_data  = data_q;

  for (genvar c = 0; c < NumCells; c++) begin : g_released
    assign o_released_onehot[c] = valid_q && i_out_ready && (cell_q == CELL_W'(c));
  end

endmodule

`default_nettype wire

// ==== rtl/bank_storage.sv ====
/*
 * Cell storage of the response bank
 * Message word array and next-cell link array, both with combinational reads
 */

`default_nettype none

module bank_storage #(
  parameter int NumIds   = resp_bank_pkg::NUM_IDS,
  parameter int NumCells = resp_bank_pkg::NUM_CELLS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_in_fire,
  input  resp_bank_pkg::msg_word_u i_in_data,
  input  resp_bank_pkg::cell_t     i_fill_addr [NumIds],
  input  logic [NumIds-1:0]        i_in_sel,
  input  logic [NumIds-1:0]        i_link_we,
  input  resp_bank_pkg::cell_t     i_link_addr [NumIds],
  input  resp_bank_pkg::cell_t     i_free_cell,
  input  resp_bank_pkg::cell_t     i_rd_cell,
  input  resp_bank_pkg::cell_t     i_mid_cell [NumIds],
  input  resp_bank_pkg::cell_t     i_head_cell [NumIds],
  output resp_bank_pkg::msg_word_u o_rd_data,
  output resp_bank_pkg::cell_t     o_mid_next [NumIds],
  output resp_bank_pkg::cell_t     o_head_next [NumIds]
);

  import resp_bank_pkg::*;

  logic [MSG_W-1:0] cells [NumCells];
  cell_t            links [NumCells];

  // Word goes to the fill cell of the queue that accepted it
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumIds; i++) begin
      if (i_in_fire && i_in_sel[i]) begin
        cells[i_fill_addr[i]] <= i_in_data.raw;
      end
    end
  end

  // At most one queue links per cycle, reservations are one-hot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      links <= '{default: '0};
    end else begin
      for (int i = 0; i < NumIds; i++) begin
        if (i_link_we[i]) begin
          links[i_link_addr[i]] <= i_free_cell;
        end
      end
    end
  end

  assign o_rd_data.raw = cells[i_rd_cell];

  for (genvar g = 0; g < NumIds; g++) begin : g_link_rd
    assign o_mid_next[g]  = links[i_mid_cell[g]];
    assign o_head_next[g] = links[i_head_cell[g]];
  end

endmodule

`default_nettype wire

// ==== rtl/id_queue/id_queue.sv ====
/*
 * Linked list bookkeeping for one identifier
 * Head, fill and tail pointers, reserved and filled counts
 */

`default_nettype none

module id_queue #(
  parameter int NumCells = resp_bank_pkg::NUM_CELLS,
  parameter int QueueId  = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     i_rsv_fire,
  input  logic                     i_rsv_sel,
  input  resp_bank_pkg::cell_t     i_free_cell,
  input  logic                     i_in_fire,
  input  resp_bank_pkg::msg_word_u i_in_data,
  input  logic                     i_pop,
  input  resp_bank_pkg::cell_t     i_mid_next,
  input  resp_bank_pkg::cell_t     i_head_next,
  output logic                     o_link_we,
  output resp_bank_pkg::cell_t     o_link_addr,
  output resp_bank_pkg::cell_t     o_fill_addr,
  output resp_bank_pkg::cell_t     o_head,
  output logic                     o_accepts,
  output logic                     o_has_filled
);

  import resp_bank_pkg::*;

  localparam int CntW = $clog2(NumCells + 1);

  cell_t           head_q;
  cell_t           fill_q;
  cell_t           tail_q;
  logic [CntW-1:0] rsv_cnt_q;
  logic [CntW-1:0] filled_cnt_q;
  logic [CntW-1:0] rsv_left;
  logic [CntW-1:0] filled_after;
  logic            rsv_take;
  logic            fill_take;
  logic            list_drained;

  ////////////////////////////////////////
  // Strobes and counts
  ////////////////////////////////////////

  assign rsv_take  = i_rsv_fire & i_rsv_sel;
  assign fill_take = i_in_fire & o_accepts;

  assign rsv_left     = rsv_cnt_q - CntW'(fill_take);
  assign filled_after = filled_cnt_q + CntW'(fill_take) - CntW'(i_pop);

  // List is empty once this cycle's fill and pop are applied
  assign list_drained = (rsv_left == '0) && (filled_after == '0);

  assign o_accepts    = (i_in_data.fields.id == ID_W'(QueueId)) && (rsv_cnt_q != '0);
  assign o_has_filled = (filled_cnt_q != '0);

  // Chain the new cell behind the current tail
  assign o_link_we   = rsv_take & ~list_drained;
  assign o_link_addr = tail_q;
  assign o_fill_addr = fill_q;
  assign o_head      = head_q;

  ////////////////////////////////////////
  // Pointer registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q       <= '0;
      fill_q       <= '0;
      tail_q       <= '0;
      rsv_cnt_q    <= '0;
      filled_cnt_q <= '0;
    end else begin
      if (fill_take) begin
        fill_q <= i_mid_next;
      end
      if (i_pop) begin
        head_q <= i_head_next;
      end
      // Reservation overrides, the link to the new cell is not readable yet
      if (rsv_take) begin
        tail_q <= i_free_cell;
        if (rsv_left == '0) begin
          fill_q <= i_free_cell;
        end
        if (list_drained) begin
          head_q <= i_free_cell;
        end
      end
      rsv_cnt_q    <= rsv_left + CntW'(rsv_take);
      filled_cnt_q <= filled_after;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/slot_allocator.sv ====
/*
 * Cell occupancy tracking
 * Lowest free cell search and reservation ready
 */

`default_nettype none

module slot_allocator #(
  parameter int NumCells = resp_bank_pkg::NUM_CELLS
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 i_rsv_valid,
  input  logic [NumCells-1:0]  i_released_onehot,
  output logic                 o_rsv_ready,
  output resp_bank_pkg::cell_t o_free_cell,
  output logic                 o_rsv_fire
);

  import resp_bank_pkg::*;

  logic [NumCells-1:0] occ_q;
  logic [NumCells-1:0] take_onehot;

  // Lowest index wins, scan from the top down
  always_comb begin
    o_free_cell = '0;
    for (int c = NumCells - 1; c >= 0; c--) begin
      if (!occ_q[c]) begin
        o_free_cell = CELL_W'(c);
      end
    end
  end

  assign o_rsv_ready = ~(&occ_q);
  assign o_rsv_fire  = i_rsv_valid & o_rsv_ready;

  for (genvar c = 0; c < NumCells; c++) begin : g_take
    assign take_onehot[c] = o_rsv_fire && (o_free_cell == CELL_W'(c));
  end

  // Released cell is always occupied, so it never collides with the taken one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= (occ_q & ~i_released_onehot) | take_onehot;
    end
  end

endmodule

`default_nettype wire

// ==== common/resp_bank_pkg.sv ====
/*
 * Shared definitions of the response bank
 * Default sizes, derived widths, message word union and cell address type
 */

`default_nettype none

package resp_bank_pkg;

  // Default sizes
  parameter int NUM_IDS   = 4;
  parameter int NUM_CELLS = 8;
  parameter int PAYLOAD_W = 8;

  // Derived widths
  parameter int ID_W   = (NUM_IDS > 1) ? $clog2(NUM_IDS) : 1;
  parameter int CELL_W = (NUM_CELLS > 1) ? $clog2(NUM_CELLS) : 1;
  parameter int MSG_W  = ID_W + PAYLOAD_W;

  // Identifier sits in the upper bits of the word
  typedef struct packed {
    logic [ID_W-1:0]      id;
    logic [PAYLOAD_W-1:0] payload;
  } msg_fields_t;

  typedef union packed {
    logic [MSG_W-1:0] raw;
    msg_fields_t      fields;
  } msg_word_u;

  typedef logic [CELL_W-1:0] cell_t;

endpackage

`default_nettype wire
